// File: rtl/dpd_pkg.sv
`default_nettype none

package dpd_pkg;

    localparam int SAMPLE_WIDTH   = 16;
    localparam int LUT_ADDR_WIDTH = 10;
    localparam int LUT_DEPTH      = 1 << LUT_ADDR_WIDTH;
    localparam int MAG_SHIFT      = 7;
    localparam int GAIN_FRAC_BITS = 14;
    localparam int REG_ADDR_WIDTH = 12;
    localparam int REG_DATA_WIDTH = 32;

    // major 1, minor 1, patch 0x61
    localparam logic [REG_DATA_WIDTH-1:0] IP_VERSION = 32'h0001_0161;

    localparam logic [REG_ADDR_WIDTH-1:0] REG_VERSION = 12'd0;
    localparam logic [REG_ADDR_WIDTH-1:0] REG_SCRATCH = 12'd1;
    localparam logic [REG_ADDR_WIDTH-1:0] REG_BYPASS  = 12'd2;
    // set for table entries, low bits carry the index
    localparam int LUT_REGION_BIT = 11;

    typedef struct packed {
        logic signed [SAMPLE_WIDTH-1:0] i;
        logic signed [SAMPLE_WIDTH-1:0] q;
    } dpd_sample_t;

    // Q2.14 complex gain, also the register layout of a table entry
    typedef struct packed {
        logic signed [SAMPLE_WIDTH-1:0] gi;
        logic signed [SAMPLE_WIDTH-1:0] gq;
    } dpd_gain_t;

    typedef logic [LUT_ADDR_WIDTH-1:0] lut_addr_t;

    typedef struct packed {
        logic        valid;
        dpd_sample_t sample;
        lut_addr_t   index;
    } stage_t;

    typedef struct packed {
        logic        valid;
        dpd_sample_t raw;
        dpd_sample_t corrected;
    } result_t;

    typedef struct packed {
        logic                      write;
        logic [REG_ADDR_WIDTH-1:0] addr;
        logic [REG_DATA_WIDTH-1:0] wdata;
    } reg_cmd_t;

    typedef struct packed {
        logic      en;
        logic      we;
        lut_addr_t addr;
        dpd_gain_t wdata;
    } lut_cfg_t;

endpackage

`default_nettype wire

// File: rtl/sample_input.sv
`default_nettype none

module sample_input (
    input  wire                  up_clk,
    input  wire                  rst_n,
    input  wire                  in_valid,
    input  wire dpd_pkg::dpd_sample_t in_sample,
    output dpd_pkg::stage_t      stage
);

    // one extra bit so that |-32768| is representable
    logic signed [dpd_pkg::SAMPLE_WIDTH:0] i_ext;
    logic signed [dpd_pkg::SAMPLE_WIDTH:0] q_ext;
    logic [dpd_pkg::SAMPLE_WIDTH:0]        abs_i;
    logic [dpd_pkg::SAMPLE_WIDTH:0]        abs_q;
    logic [dpd_pkg::SAMPLE_WIDTH:0]        mag_sum;
    dpd_pkg::lut_addr_t                    index_next;

    logic                 valid_q;
    dpd_pkg::dpd_sample_t sample_q;
    dpd_pkg::lut_addr_t   index_q;

    assign i_ext = in_sample.i;
    assign q_ext = in_sample.q;

    assign abs_i = i_ext[dpd_pkg::SAMPLE_WIDTH] ? -i_ext : i_ext;
    assign abs_q = q_ext[dpd_pkg::SAMPLE_WIDTH] ? -q_ext : q_ext;

    // at most 65536, so the shifted sum tops out at 512
    assign mag_sum    = abs_i + abs_q;
    assign index_next = dpd_pkg::lut_addr_t'(mag_sum >> dpd_pkg::MAG_SHIFT);

    always_ff @(posedge up_clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge up_clk) begin
        sample_q <= in_sample;
        index_q  <= index_next;
    end

    assign stage = '{valid: valid_q, sample: sample_q, index: index_q};

endmodule

`default_nettype wire

// File: rtl/gain_lut.sv
`default_nettype none

module gain_lut (
    input  wire                     up_clk,
    input  wire dpd_pkg::lut_addr_t rd_addr,
    output dpd_pkg::dpd_gain_t      rd_gain,
    input  wire dpd_pkg::lut_cfg_t  cfg,
    output dpd_pkg::dpd_gain_t      cfg_rdata
);

    dpd_pkg::dpd_gain_t mem [dpd_pkg::LUT_DEPTH];

    // datapath port, read only
    always_ff @(posedge up_clk) begin
        rd_gain <= mem[rd_addr];
    end

    // config port
    // a write colliding with a datapath read leaves the old value on rd_gain
    always_ff @(posedge up_clk) begin
        if (cfg.en) begin
            if (cfg.we) begin
                mem[cfg.addr] <= cfg.wdata;
            end else begin
                cfg_rdata <= mem[cfg.addr];
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/gain_multiplier.sv
`default_nettype none

module gain_multiplier (
    input  wire                     up_clk,
    input  wire                     rst_n,
    input  wire dpd_pkg::stage_t    stage,
    input  wire dpd_pkg::dpd_gain_t gain,
    output dpd_pkg::result_t        result
);

    // sample held beside the table read
    logic                 hold_valid;
    dpd_pkg::dpd_sample_t hold_sample;

    // product stage
    logic                                      prod_valid;
    dpd_pkg::dpd_sample_t                      prod_raw;
    logic signed [2*dpd_pkg::SAMPLE_WIDTH-1:0] p_ii;
    logic signed [2*dpd_pkg::SAMPLE_WIDTH-1:0] p_qq;
    logic signed [2*dpd_pkg::SAMPLE_WIDTH-1:0] p_iq;
    logic signed [2*dpd_pkg::SAMPLE_WIDTH-1:0] p_qi;

    logic signed [2*dpd_pkg::SAMPLE_WIDTH:0] acc_i;
    logic signed [2*dpd_pkg::SAMPLE_WIDTH:0] acc_q;

    logic                 res_valid;
    dpd_pkg::dpd_sample_t res_raw;
    dpd_pkg::dpd_sample_t res_corr;

    function automatic logic signed [dpd_pkg::SAMPLE_WIDTH-1:0] round_sat(
        input logic signed [2*dpd_pkg::SAMPLE_WIDTH:0] acc
    );
        logic signed [2*dpd_pkg::SAMPLE_WIDTH:0] rnd;
        logic signed [2*dpd_pkg::SAMPLE_WIDTH:0] shifted;
        logic signed [2*dpd_pkg::SAMPLE_WIDTH:0] max_v;
        logic signed [2*dpd_pkg::SAMPLE_WIDTH:0] min_v;
        rnd     = 1 <<< (dpd_pkg::GAIN_FRAC_BITS - 1);
        max_v   = 2 ** (dpd_pkg::SAMPLE_WIDTH - 1) - 1;
        min_v   = -(2 ** (dpd_pkg::SAMPLE_WIDTH - 1));
        shifted = (acc + rnd) >>> dpd_pkg::GAIN_FRAC_BITS;
        if (shifted > max_v) begin
            return max_v[dpd_pkg::SAMPLE_WIDTH-1:0];
        end else if (shifted < min_v) begin
            return min_v[dpd_pkg::SAMPLE_WIDTH-1:0];
        end
        return shifted[dpd_pkg::SAMPLE_WIDTH-1:0];
    endfunction

    always_ff @(posedge up_clk or negedge rst_n) begin
        if (!rst_n) begin
            hold_valid <= 1'b0;
            prod_valid <= 1'b0;
            res_valid  <= 1'b0;
        end else begin
            hold_valid <= stage.valid;
            prod_valid <= hold_valid;
            res_valid  <= prod_valid;
        end
    end

    always_ff @(posedge up_clk) begin
        hold_sample <= stage.sample;
        prod_raw    <= hold_sample;
        p_ii        <= hold_sample.i * gain.gi;
        p_qq        <= hold_sample.q * gain.gq;
        p_iq        <= hold_sample.i * gain.gq;
        p_qi        <= hold_sample.q * gain.gi;
        res_raw     <= prod_raw;
        res_corr    <= '{i: round_sat(acc_i), q: round_sat(acc_q)};
    end

    // (i + jq)(gi + jgq)
    assign acc_i = p_ii - p_qq;
    assign acc_q = p_iq + p_qi;

    assign result = '{valid: res_valid, raw: res_raw, corrected: res_corr};

endmodule

`default_nettype wire

// File: rtl/sample_output.sv
`default_nettype none

module sample_output (
    input  wire                   up_clk,
    input  wire                   rst_n,
    input  wire dpd_pkg::result_t result,
    input  wire                   bypass,
    output logic                  out_valid,
    output dpd_pkg::dpd_sample_t  out_sample
);

    dpd_pkg::dpd_sample_t sel_sample;

    // raw and corrected arrive together, so bypass keeps the latency
    assign sel_sample = bypass ? result.raw : result.corrected;

    always_ff @(posedge up_clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid  <= 1'b0;
            out_sample <= '0;
        end else begin
            out_valid <= result.valid;
            // idle cycles drive zero data
            if (result.valid) begin
                out_sample <= sel_sample;
            end else begin
                out_sample <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/reg_access.sv
`default_nettype none

module reg_access (
    input  wire                                  up_clk,
    input  wire                                  rst_n,
    input  wire                                  reg_req,
    input  wire dpd_pkg::reg_cmd_t               reg_cmd,
    output logic                                 reg_ack,
    output logic [dpd_pkg::REG_DATA_WIDTH-1:0]   reg_rdata,
    output dpd_pkg::lut_cfg_t                    lut_cfg,
    input  wire dpd_pkg::dpd_gain_t              lut_rdata,
    output logic                                 bypass
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_TABLE_WAIT,
        ST_ACK,
        ST_RELEASE
    } state_t;

    state_t                              state;
    logic [dpd_pkg::REG_DATA_WIDTH-1:0]  scratch;
    logic [dpd_pkg::REG_DATA_WIDTH-1:0]  reg_read;
    logic [dpd_pkg::REG_DATA_WIDTH-1:0]  rdata_q;
    logic                                rd_lut;
    logic                                lut_hit;

    assign lut_hit = reg_cmd.addr[dpd_pkg::LUT_REGION_BIT];

    // register map, unmapped reads give zero
    always_comb begin
        case (reg_cmd.addr)
            dpd_pkg::REG_VERSION: reg_read = dpd_pkg::IP_VERSION;
            dpd_pkg::REG_SCRATCH: reg_read = scratch;
            dpd_pkg::REG_BYPASS:  reg_read = {{(dpd_pkg::REG_DATA_WIDTH-1){1'b0}}, bypass};
            default:              reg_read = '0;
        endcase
    end

    always_ff @(posedge up_clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            scratch <= '0;
            bypass  <= 1'b0;
            rd_lut  <= 1'b0;
            lut_cfg <= '0;
        end else begin
            // table accesses last one cycle
            lut_cfg.en <= 1'b0;
            lut_cfg.we <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (reg_req) begin
                        rd_lut <= lut_hit && !reg_cmd.write;
                        if (lut_hit) begin
                            lut_cfg.en    <= 1'b1;
                            lut_cfg.we    <= reg_cmd.write;
                            lut_cfg.addr  <= reg_cmd.addr[dpd_pkg::LUT_ADDR_WIDTH-1:0];
                            lut_cfg.wdata <= dpd_pkg::dpd_gain_t'(reg_cmd.wdata);
                            state <= reg_cmd.write ? ST_ACK : ST_TABLE_WAIT;
                        end else begin
                            if (reg_cmd.write && reg_cmd.addr == dpd_pkg::REG_SCRATCH) begin
                                scratch <= reg_cmd.wdata;
                            end
                            if (reg_cmd.write && reg_cmd.addr == dpd_pkg::REG_BYPASS) begin
                                bypass <= reg_cmd.wdata[0];
                            end
                            state <= ST_ACK;
                        end
                    end
                end
                // table output is valid from the next cycle
                ST_TABLE_WAIT: state <= ST_ACK;
                ST_ACK: begin
                    if (!reg_req) begin
                        state <= ST_RELEASE;
                    end
                end
                ST_RELEASE: state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge up_clk) begin
        if (state == ST_IDLE && reg_req) begin
            rdata_q <= reg_cmd.write ? '0 : reg_read;
        end
    end

    assign reg_ack = (state == ST_ACK);

    // table read data stays put while ack is high, no new access is issued
    assign reg_rdata = !reg_ack ? '0 : (rd_lut ? lut_rdata : rdata_q);

endmodule

`default_nettype wire

// File: rtl/dpd_actuator_top.sv
`default_nettype none

module dpd_actuator_top (
    input  wire                                up_clk,
    input  wire                                rst_n,

    // sample stream, no back-pressure
    input  wire                                in_valid,
    input  wire dpd_pkg::dpd_sample_t          in_sample,
    output logic                               out_valid,
    output dpd_pkg::dpd_sample_t               out_sample,

    // four-phase register port
    input  wire                                reg_req,
    input  wire dpd_pkg::reg_cmd_t             reg_cmd,
    output logic                               reg_ack,
    output logic [dpd_pkg::REG_DATA_WIDTH-1:0] reg_rdata
);

    dpd_pkg::stage_t    stage;
    dpd_pkg::dpd_gain_t gain;
    dpd_pkg::result_t   result;
    dpd_pkg::lut_cfg_t  lut_cfg;
    dpd_pkg::dpd_gain_t lut_rdata;
    logic               bypass;

    sample_input sample_input_i (
        .up_clk    (up_clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_sample (in_sample),
        .stage     (stage)
    );

    gain_lut gain_lut_i (
        .up_clk    (up_clk),
        .rd_addr   (stage.index),
        .rd_gain   (gain),
        .cfg       (lut_cfg),
        .cfg_rdata (lut_rdata)
    );

    gain_multiplier gain_multiplier_i (
        .up_clk (up_clk),
        .rst_n  (rst_n),
        .stage  (stage),
        .gain   (gain),
        .result (result)
    );

    sample_output sample_output_i (
        .up_clk     (up_clk),
        .rst_n      (rst_n),
        .result     (result),
        .bypass     (bypass),
        .out_valid  (out_valid),
        .out_sample (out_sample)
    );

    reg_access reg_access_i (
        .up_clk    (up_clk),
        .rst_n     (rst_n),
        .reg_req   (reg_req),
        .reg_cmd   (reg_cmd),
        .reg_ack   (reg_ack),
        .reg_rdata (reg_rdata),
        .lut_cfg   (lut_cfg),
        .lut_rdata (lut_rdata),
        .bypass    (bypass)
    );

endmodule

`default_nettype wire

// File: testbench/dpd_actuator_tb.sv
`default_nettype none

module dpd_actuator_tb;

    typedef enum logic [2:0] {OP_WR, OP_RD, OP_SMP, OP_RND, OP_GAP} op_t;

    typedef struct packed {
        op_t         op;
        logic [11:0] addr;
        logic [31:0] data;
    } row_t;

    localparam logic [31:0] UNITY = 32'h4000_0000;

    logic                 up_clk = 1'b0;
    logic                 rst_n;
    logic                 in_valid;
    dpd_pkg::dpd_sample_t in_sample;
    logic                 out_valid;
    dpd_pkg::dpd_sample_t out_sample;
    logic                 reg_req;
    dpd_pkg::reg_cmd_t    reg_cmd;
    logic                 reg_ack;
    logic [31:0]          reg_rdata;

    row_t                 rows[$];
    dpd_pkg::dpd_gain_t   lut_model [dpd_pkg::LUT_DEPTH];
    logic                 bypass_model = 1'b0;
    dpd_pkg::dpd_sample_t exp_data[$];
    int                   exp_due[$];
    int                   cycles = 0;
    int                   cycle_limit = 0;
    int                   seed;

    dpd_actuator_top dpd_actuator_top_i (
        .up_clk     (up_clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_sample  (in_sample),
        .out_valid  (out_valid),
        .out_sample (out_sample),
        .reg_req    (reg_req),
        .reg_cmd    (reg_cmd),
        .reg_ack    (reg_ack),
        .reg_rdata  (reg_rdata)
    );

    always #10 up_clk = ~up_clk;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped on failure");
    endtask

    task automatic check_equal(input logic [31:0] got, input logic [31:0] expected,
                               input string what);
        if (got !== expected) begin
            report_failure($sformatf("mismatch at time %0t: %s, got %h expected %h",
                                     $time, what, got, expected));
        end
    endtask

    always @(posedge up_clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            report_failure($sformatf("timeout: run went past %0d cycles", cycle_limit));
        end
    end

    function automatic logic [15:0] round_saturate(input longint acc);
        longint v;
        v = (acc + (1 << (dpd_pkg::GAIN_FRAC_BITS - 1))) >>> dpd_pkg::GAIN_FRAC_BITS;
        if (v > 32767) begin
            return 16'h7fff;
        end else if (v < -32768) begin
            return 16'h8000;
        end
        return v[15:0];
    endfunction

    // reference model of the sample path
    function automatic dpd_pkg::dpd_sample_t expected_out(input dpd_pkg::dpd_sample_t s);
        int                 mag;
        longint             acc_i;
        longint             acc_q;
        dpd_pkg::dpd_gain_t g;
        if (bypass_model) begin
            return s;
        end
        mag = (s.i < 0 ? -int'(s.i) : int'(s.i)) + (s.q < 0 ? -int'(s.q) : int'(s.q));
        g = lut_model[mag >> dpd_pkg::MAG_SHIFT];
        acc_i = longint'(s.i) * g.gi - longint'(s.q) * g.gq;
        acc_q = longint'(s.i) * g.gq + longint'(s.q) * g.gi;
        return '{i: round_saturate(acc_i), q: round_saturate(acc_q)};
    endfunction

    function automatic dpd_pkg::dpd_sample_t small_random_sample();
        logic [31:0] rnd;
        rnd = $random(seed);
        // 9-bit signed parts keep the index within 0..4
        return '{i: {{7{rnd[24]}}, rnd[24:16]}, q: {{7{rnd[8]}}, rnd[8:0]}};
    endfunction

    task automatic drive_sample(input logic valid, input dpd_pkg::dpd_sample_t s);
        @(negedge up_clk);
        in_valid  = valid;
        in_sample = s;
        if (valid) begin
            exp_data.push_back(expected_out(s));
            // accepted at the next edge, out four edges later
            exp_due.push_back(cycles + 5);
        end
    endtask

    task automatic reg_transfer(input logic write, input logic [11:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata);
        @(negedge up_clk);
        reg_cmd = '{write: write, addr: addr, wdata: wdata};
        reg_req = 1'b1;
        while (!reg_ack) begin
            @(negedge up_clk);
        end
        rdata   = reg_rdata;
        reg_req = 1'b0;
        while (reg_ack) begin
            @(negedge up_clk);
        end
    endtask

    task automatic apply_row(input row_t r);
        logic [31:0] rdata;
        case (r.op)
            OP_SMP: drive_sample(1'b1, r.data);
            OP_RND: drive_sample(1'b1, small_random_sample());
            OP_GAP: drive_sample(1'b0, r.data);
            default: begin
                // let the pipeline drain before touching registers
                drive_sample(1'b0, '0);
                while (exp_data.size() != 0) begin
                    @(negedge up_clk);
                end
                reg_transfer(r.op == OP_WR, r.addr, r.data, rdata);
                if (r.op == OP_WR) begin
                    check_equal(rdata, 32'h0, "read data on a write ack");
                    if (r.addr[dpd_pkg::LUT_REGION_BIT]) begin
                        lut_model[r.addr[9:0]] = r.data;
                    end else if (r.addr == dpd_pkg::REG_BYPASS) begin
                        bypass_model = r.data[0];
                    end
                end else begin
                    check_equal(rdata, r.data, $sformatf("register read at %h", r.addr));
                end
            end
        endcase
    endtask

    task automatic add_row(input op_t op, input logic [11:0] addr, input logic [31:0] data);
        rows.push_back('{op: op, addr: addr, data: data});
    endtask

    always @(negedge up_clk) begin
        if (rst_n && out_valid) begin
            if (exp_data.size() == 0) begin
                report_failure("out_valid went high with no sample in flight");
            end else begin
                check_equal(cycles, exp_due[0], "output cycle");
                check_equal(out_sample, exp_data[0], "output sample");
                void'(exp_data.pop_front());
                void'(exp_due.pop_front());
            end
        end else if (rst_n) begin
            check_equal(out_sample, 32'h0, "output data while idle");
            if (exp_due.size() != 0 && exp_due[0] <= cycles) begin
                report_failure("an accepted sample never reached the output");
            end
        end
    end

    initial begin
        seed      = 32'hb48ec633;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_sample = '0;
        reg_req   = 1'b0;
        reg_cmd   = '0;

        add_row(OP_RD, 12'h000, dpd_pkg::IP_VERSION);
        add_row(OP_WR, 12'h001, 32'hc3a5_5a3c);
        add_row(OP_RD, 12'h001, 32'hc3a5_5a3c);
        add_row(OP_RD, 12'h005, 32'h0);
        add_row(OP_WR, 12'h7ff, 32'hffff_ffff);
        add_row(OP_RD, 12'h7ff, 32'h0);
        // unity where the small random samples land
        for (int n = 0; n < 5; n++) begin
            add_row(OP_WR, 12'h800 + 12'(n), UNITY);
        end
        add_row(OP_WR, 12'h80a, 32'h2000_1000);
        add_row(OP_WR, 12'h864, 32'hc000_2000);
        add_row(OP_WR, 12'h8ea, 32'h7fff_0000);
        add_row(OP_WR, 12'h938, 32'h7000_7000);
        add_row(OP_RD, 12'h803, UNITY);
        add_row(OP_RD, 12'h80a, 32'h2000_1000);
        add_row(OP_RD, 12'h864, 32'hc000_2000);
        add_row(OP_RD, 12'h8ea, 32'h7fff_0000);
        add_row(OP_RD, 12'h938, 32'h7000_7000);
        repeat (12) add_row(OP_RND, 12'h0, 32'h0);
        // indices 10, 100, 234, 234, 312
        add_row(OP_SMP, 12'h0, {16'sd1280, 16'sd100});
        add_row(OP_SMP, 12'h0, {-16'sd9000, 16'sd3900});
        add_row(OP_SMP, 12'h0, {16'sd30000, 16'sd0});
        add_row(OP_SMP, 12'h0, {-16'sd30000, 16'sd0});
        add_row(OP_SMP, 12'h0, {16'sd20000, 16'sd20000});
        add_row(OP_WR, 12'h002, 32'h1);
        add_row(OP_RD, 12'h002, 32'h1);
        add_row(OP_SMP, 12'h0, {16'sd30000, 16'sd0});
        add_row(OP_SMP, 12'h0, {16'sd1280, 16'sd100});
        repeat (3) add_row(OP_RND, 12'h0, 32'h0);
        add_row(OP_WR, 12'h002, 32'h0);
        add_row(OP_SMP, 12'h0, {16'sd30000, 16'sd0});
        // gaps carry junk data that must not show up
        add_row(OP_GAP, 12'h0, 32'hdead_beef);
        add_row(OP_GAP, 12'h0, 32'h1234_5678);
        add_row(OP_SMP, 12'h0, {-16'sd9000, 16'sd3900});
        add_row(OP_GAP, 12'h0, 32'hdead_beef);
        add_row(OP_RND, 12'h0, 32'h0);
        add_row(OP_GAP, 12'h0, 32'h8000_8000);
        repeat (4) add_row(OP_RND, 12'h0, 32'h0);
        cycle_limit = rows.size() * 20 + 200;

        repeat (10) @(posedge up_clk);
        @(negedge up_clk);
        rst_n = 1'b1;
        check_equal(out_valid, 1'b0, "out_valid after reset");
        check_equal(reg_ack, 1'b0, "reg_ack after reset");

        foreach (rows[n]) begin
            apply_row(rows[n]);
        end
        drive_sample(1'b0, '0);
        while (exp_data.size() != 0) begin
            @(negedge up_clk);
        end
        repeat (3) @(negedge up_clk);

        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
rtl/dpd_pkg.sv
rtl/sample_input.sv
rtl/gain_lut.sv
rtl/gain_multiplier.sv
rtl/sample_output.sv
rtl/reg_access.sv
rtl/dpd_actuator_top.sv
testbench/dpd_actuator_tb.sv
